// File: Bender.yml
package:
  name: rv_div_unit

sources:
  - files:
      - design/rv_m_pkg.sv
      - design/div_cfg_pkg.sv
      - design/div_op_if.sv
      - design/div_operand_prep.sv
      - design/div_iter_engine.sv
      - design/rv_div_unit.sv
  - target: test
    files:
      - tests/rv_div_unit_sva.sv
      - tests/rv_div_unit_tb.sv

// File: design/div_cfg_pkg.sv
package div_cfg_pkg;

  // ----------------------------------------
  // engine control
  // ----------------------------------------
  typedef enum logic [1:0] {
    IDLE,    // waiting for a start
    DIVIDE,  // one restoring step per cycle
    DONE     // result held until ready
  } div_state_e;

  typedef logic [6:0] iter_cnt_t;  // holds up to 64

  // iterations per operation width
  localparam iter_cnt_t ITER_XLEN = 7'd64;
  localparam iter_cnt_t ITER_WORD = 7'd32;

  // ----------------------------------------
  // datapath
  // ----------------------------------------
  // {partial remainder, dividend / quotient}
  typedef logic [127:0] acc_t;

endpackage

// File: design/div_iter_engine.sv
`timescale 1ns/1ps

module div_iter_engine import rv_m_pkg::*, div_cfg_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  div_op_if.engine op_i,
  input  logic     ready_i,
  output xlen_t    result_o,
  output logic     busy_o,
  output logic     done_o
);

  // control state
  div_state_e state_q;
  iter_cnt_t  cnt_q;
  logic       done_q;
  xlen_t      result_q;

  // operation payload
  acc_t       acc_q;      // {remainder, quotient}
  xlen_t      divisor_q;
  logic       neg_q_q;
  logic       neg_r_q;
  logic       is_rem_q;
  logic       is_word_q;

  logic       accept;

  // step datapath
  logic [64:0] partial;  // shifted remainder with carry bit
  logic [65:0] diff;
  logic        fits;
  acc_t        acc_step;

  // fix-up datapath
  xlen_t quot;
  xlen_t rem;
  xlen_t sel;
  xlen_t fixed;

  assign accept = (state_q == IDLE) & op_i.start;

  // ----------------------------------------
  // restoring step
  // ----------------------------------------
  assign partial = acc_q[127:63];
  assign diff    = {1'b0, partial} - {2'b0, divisor_q};
  assign fits    = ~diff[65];  // no borrow, partial >= divisor

  always_comb begin
    if (fits) begin
      acc_step = {diff[63:0], acc_q[62:0], 1'b1};
    end else begin
      acc_step = {partial[63:0], acc_q[62:0], 1'b0};
    end
  end

  // ----------------------------------------
  // result fix-up
  // ----------------------------------------
  assign quot = neg_q_q ? -acc_q[63:0] : acc_q[63:0];
  assign rem  = neg_r_q ? -acc_q[127:64] : acc_q[127:64];
  assign sel  = is_rem_q ? rem : quot;

  // every word form returns sext of the low 32 bits
  assign fixed = is_word_q ? {{32{sel[31]}}, sel[31:0]} : sel;

  // ----------------------------------------
  // fsm
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q  <= IDLE;
      cnt_q    <= '0;
      done_q   <= 1'b0;
      result_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept && op_i.special) begin
            result_q <= op_i.special_result;  // no iterations needed
            done_q   <= 1'b1;
            state_q  <= DONE;
          end else if (accept) begin
            cnt_q   <= op_i.iter_count;
            state_q <= DIVIDE;
          end
        end
        DIVIDE: begin
          cnt_q <= cnt_q - 7'd1;
          if (cnt_q == 7'd1) begin
            state_q <= DONE;  // last step this cycle
          end
        end
        DONE: begin
          if (!done_q) begin
            result_q <= fixed;
            done_q   <= 1'b1;
          end else if (ready_i) begin
            done_q  <= 1'b0;  // transfer
            state_q <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // payload, loaded on accept and stepped while dividing
  always_ff @(posedge clk) begin
    if (accept) begin
      acc_q     <= {64'b0, op_i.dividend_mag};
      divisor_q <= op_i.divisor_mag;
      neg_q_q   <= op_i.neg_q;
      neg_r_q   <= op_i.neg_r;
      is_rem_q  <= op_i.is_rem;
      is_word_q <= op_i.is_word;
    end else if (state_q == DIVIDE) begin
      acc_q <= acc_step;
    end
  end

  assign result_o = result_q;
  assign busy_o   = (state_q != IDLE);
  assign done_o   = done_q;

endmodule

// File: design/div_op_if.sv
`timescale 1ns/1ps

interface div_op_if import rv_m_pkg::*, div_cfg_pkg::*; ();

  logic      start;           // start strobe
  logic      special;         // zero divisor or overflow
  xlen_t     special_result;  // architectural result for special cases
  xlen_t     dividend_mag;    // word forms sit in the upper half
  xlen_t     divisor_mag;
  iter_cnt_t iter_count;      // steps to run
  logic      neg_q;           // negate quotient at the end
  logic      neg_r;           // negate remainder at the end
  logic      is_rem;
  logic      is_word;

  // operand preparation side
  modport prep (
    output start, special, special_result,
    output dividend_mag, divisor_mag, iter_count,
    output neg_q, neg_r, is_rem, is_word
  );

  // iteration engine side
  modport engine (
    input start, special, special_result,
    input dividend_mag, divisor_mag, iter_count,
    input neg_q, neg_r, is_rem, is_word
  );

endinterface

// File: design/div_operand_prep.sv
`timescale 1ns/1ps

module div_operand_prep import rv_m_pkg::*, div_cfg_pkg::*; (
  input  div_op_t op_i,
  input  xlen_t   dividend_i,
  input  xlen_t   divisor_i,
  input  logic    valid_i,
  div_op_if.prep  op_o
);

  logic  is_unsigned;
  logic  is_rem;
  logic  is_word;

  xlen_t op_a;     // dividend after word extension
  xlen_t op_b;     // divisor after word extension
  logic  sign_a;
  logic  sign_b;
  xlen_t mag_a;
  xlen_t mag_b;

  xlen_t min_neg;  // most negative value for this width
  logic  div_zero;
  logic  overflow;
  xlen_t special_result;

  function automatic xlen_t sext_word(word_t w);
    return {{32{w[31]}}, w};
  endfunction

  // ----------------------------------------
  // decode
  // ----------------------------------------
  assign is_unsigned = op_i[OP_BIT_UNSIGNED];
  assign is_rem      = op_i[OP_BIT_REM];
  assign is_word     = op_i[OP_BIT_WORD];

  // word operands: zero extend for unsigned, sign extend otherwise
  always_comb begin
    if (is_word && is_unsigned) begin
      op_a = {32'b0, dividend_i[31:0]};
      op_b = {32'b0, divisor_i[31:0]};
    end else if (is_word) begin
      op_a = sext_word(dividend_i[31:0]);
      op_b = sext_word(divisor_i[31:0]);
    end else begin
      op_a = dividend_i;
      op_b = divisor_i;
    end
  end

  // ----------------------------------------
  // magnitudes and result signs
  // ----------------------------------------
  assign sign_a = ~is_unsigned & op_a[63];
  assign sign_b = ~is_unsigned & op_b[63];

  assign mag_a = sign_a ? -op_a : op_a;
  assign mag_b = sign_b ? -op_b : op_b;  // 2^31 / 2^63 still fits unsigned

  // ----------------------------------------
  // special cases
  // ----------------------------------------
  assign div_zero = is_word ? (divisor_i[31:0] == '0) : (divisor_i == '0);

  assign min_neg  = is_word ? sext_word(32'h8000_0000) : {1'b1, 63'b0};
  assign overflow = ~is_unsigned & (op_a == min_neg) & (&op_b);  // min / -1

  always_comb begin
    special_result = '0;
    if (div_zero) begin
      if (is_rem) begin
        special_result = is_word ? sext_word(dividend_i[31:0]) : dividend_i;
      end else begin
        special_result = '1;  // quotient by zero is all ones
      end
    end else if (overflow) begin
      special_result = is_rem ? '0 : min_neg;
    end
  end

  // ----------------------------------------
  // to the engine
  // ----------------------------------------
  assign op_o.start          = valid_i;
  assign op_o.special        = div_zero | overflow;
  assign op_o.special_result = special_result;

  // word dividend goes on top so 32 shifts bring it into the remainder
  assign op_o.dividend_mag = is_word ? {mag_a[31:0], 32'b0} : mag_a;
  assign op_o.divisor_mag  = is_word ? {32'b0, mag_b[31:0]} : mag_b;
  assign op_o.iter_count   = is_word ? ITER_WORD : ITER_XLEN;

  assign op_o.neg_q   = sign_a ^ sign_b;
  assign op_o.neg_r   = sign_a;  // remainder follows the dividend
  assign op_o.is_rem  = is_rem;
  assign op_o.is_word = is_word;

endmodule

// File: design/rv_div_unit.sv
`timescale 1ns/1ps

module rv_div_unit import rv_m_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,

  // request
  input  logic    valid_i,     // one cycle start, taken only when idle
  input  div_op_t op_i,
  input  xlen_t   dividend_i,
  input  xlen_t   divisor_i,

  // response
  input  logic    ready_i,     // consumer takes result when done_o is high
  output xlen_t   result_o,
  output logic    busy_o,
  output logic    done_o
);

  // ----------------------------------------
  // prepared operation
  // ----------------------------------------
  div_op_if op_if ();

  // combinational decode, magnitudes and special cases
  div_operand_prep u_prep (
    .op_i       (op_i),
    .dividend_i (dividend_i),
    .divisor_i  (divisor_i),
    .valid_i    (valid_i),
    .op_o       (op_if)
  );

  // ----------------------------------------
  // shift-subtract engine
  // ----------------------------------------
  div_iter_engine u_engine (
    .clk      (clk),
    .rst_n    (rst_n),
    .op_i     (op_if),
    .ready_i  (ready_i),
    .result_o (result_o),
    .busy_o   (busy_o),
    .done_o   (done_o)
  );

endmodule

// File: design/rv_m_pkg.sv
package rv_m_pkg;

  // ----------------------------------------
  // data widths
  // ----------------------------------------
  typedef logic [63:0] xlen_t;  // full register width
  typedef logic [31:0] word_t;  // *W operation slice

  // ----------------------------------------
  // operation code, {word, rem, unsigned}
  // ----------------------------------------
  typedef logic [2:0] div_op_t;

  localparam int OP_BIT_UNSIGNED = 0;
  localparam int OP_BIT_REM      = 1;
  localparam int OP_BIT_WORD     = 2;

  // full width forms
  localparam div_op_t OP_DIV   = 3'b000;
  localparam div_op_t OP_DIVU  = 3'b001;
  localparam div_op_t OP_REM   = 3'b010;
  localparam div_op_t OP_REMU  = 3'b011;

  // word forms, results sign extended from bit 31
  localparam div_op_t OP_DIVW  = 3'b100;
  localparam div_op_t OP_DIVUW = 3'b101;
  localparam div_op_t OP_REMW  = 3'b110;
  localparam div_op_t OP_REMUW = 3'b111;

endpackage

// File: rv_div_unit.f
design/rv_m_pkg.sv
design/div_cfg_pkg.sv
design/div_op_if.sv
design/div_operand_prep.sv
design/div_iter_engine.sv
design/rv_div_unit.sv
tests/rv_div_unit_sva.sv
tests/rv_div_unit_tb.sv

// File: tests/div_tests.txt
// op dividend divisor expected ready_delay
// op is {word, rem, unsigned} in hex, values in hex, delay in cycles
0 0000000000000064 0000000000000007 000000000000000e 0
0 ffffffffffffff9c 0000000000000007 fffffffffffffff2 2
2 ffffffffffffff9c 0000000000000007 fffffffffffffffe 0
2 0000000000000064 fffffffffffffff9 0000000000000002 1
0 ffffffffffffff9c fffffffffffffff9 000000000000000e 0
0 7fffffffffffffff fffffffffffffffe c000000000000001 0
1 ffffffffffffffff 0000000000000002 7fffffffffffffff 0
3 ffffffffffffffff 000000000000000a 0000000000000005 3
3 123456789abcdef0 0000000000000100 00000000000000f0 4
1 8000000000000000 ffffffffffffffff 0000000000000000 0
0 0000000000001234 0000000000000000 ffffffffffffffff 0
2 8000000000000123 0000000000000000 8000000000000123 1
0 8000000000000000 ffffffffffffffff 8000000000000000 0
2 8000000000000000 ffffffffffffffff 0000000000000000 2
4 deadbeeffffffff6 1234567800000003 fffffffffffffffd 0
6 deadbeeffffffff6 1234567800000003 ffffffffffffffff 1
5 00000001fffffff6 0000000000000003 0000000055555552 0
5 00000000ffffffff ffffffff00000001 ffffffffffffffff 0
7 fffffffffffffff7 1234567800000002 0000000000000001 0
4 0000000000000001 ffffffff00000000 ffffffffffffffff 0
6 aaaaaaaa87654321 0000000500000000 ffffffff87654321 2
4 0000000080000000 00000000ffffffff ffffffff80000000 0
6 0000000080000000 00000000ffffffff 0000000000000000 0

// File: tests/rv_div_unit_sva.sv
`timescale 1ns/1ps

module rv_div_unit_sva import rv_m_pkg::*; (
  input logic  clk,
  input logic  rst_n,
  input logic  valid_i,
  input logic  ready_i,
  input xlen_t result_o,
  input logic  busy_o,
  input logic  done_o
);

  // ----------------------------------------
  // handshake
  // ----------------------------------------
  a_done_busy : assert property (@(posedge clk) disable iff (rst_n)
    done_o |-> busy_o)
    else $error("done_o high while busy_o is low");

  // back-pressure holds the result
  a_hold : assert property (@(posedge clk) disable iff (rst_n)
    done_o && !ready_i |=> done_o && $stable(result_o))
    else $error("result dropped or changed before ready_i");

  a_start : assert property (@(posedge clk) disable iff (rst_n)
    valid_i && !busy_o |=> busy_o)
    else $error("start while idle did not raise busy_o");

endmodule

bind rv_div_unit rv_div_unit_sva u_sva (
  .clk      (clk),
  .rst_n    (rst_n),
  .valid_i  (valid_i),
  .ready_i  (ready_i),
  .result_o (result_o),
  .busy_o   (busy_o),
  .done_o   (done_o)
);

// File: tests/rv_div_unit_tb.sv
`timescale 1ns/1ps

module rv_div_unit_tb import rv_m_pkg::*, div_cfg_pkg::*; ();

  localparam int CLK_PERIOD = 8;
  localparam int N_RANDOM   = 200;

  logic    clk;
  logic    rst_n;
  logic    valid_i;
  div_op_t op_i;
  xlen_t   dividend_i;
  xlen_t   divisor_i;
  logic    ready_i;
  xlen_t   result_o;
  logic    busy_o;
  logic    done_o;

  // directed vectors from the data file
  div_op_t vec_op[$];
  xlen_t   vec_a[$];
  xlen_t   vec_b[$];
  xlen_t   vec_exp[$];
  int      vec_delay[$];
  bit      loaded = 1'b0;

  int          errors = 0;
  int          n_ops  = 0;
  logic [31:0] rng_state = 32'hf3999dcf;

  rv_div_unit DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid_i    (valid_i),
    .op_i       (op_i),
    .dividend_i (dividend_i),
    .divisor_i  (divisor_i),
    .ready_i    (ready_i),
    .result_o   (result_o),
    .busy_o     (busy_o),
    .done_o     (done_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [31:0] next_random();
    logic [31:0] s;
    s = rng_state;
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    rng_state = s;
    return s;
  endfunction

  // zero divisor or signed min / -1 (low half only for word forms)
  function automatic logic is_special(div_op_t op, xlen_t a, xlen_t b);
    logic is_u;
    is_u = op[OP_BIT_UNSIGNED];
    if (op[OP_BIT_WORD]) begin
      return (b[31:0] == '0) ||
             (!is_u && a[31:0] == 32'h8000_0000 && b[31:0] == 32'hffff_ffff);
    end
    return (b == '0) || (!is_u && a == {1'b1, 63'b0} && b == '1);
  endfunction

  // cycles from driving valid_i to seeing done_o including the accept edge
  function automatic int expected_latency(div_op_t op, xlen_t a, xlen_t b);
    if (is_special(op, a, b)) begin
      return 1;
    end
    return op[OP_BIT_WORD] ? int'(ITER_WORD) + 2 : int'(ITER_XLEN) + 2;
  endfunction

  // ISA reference for all eight forms
  function automatic xlen_t ref_div(div_op_t op, xlen_t a, xlen_t b);
    logic               is_u;
    logic               is_r;
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [31:0] wa;
    logic signed [31:0] wb;
    word_t              wres;
    is_u = op[OP_BIT_UNSIGNED];
    is_r = op[OP_BIT_REM];
    if (op[OP_BIT_WORD]) begin
      wa = a[31:0];
      wb = b[31:0];
      if (wb == 0) wres = is_r ? a[31:0] : 32'hffff_ffff;
      else if (!is_u && wa == 32'sh8000_0000 && wb == -32'sd1) wres = is_r ? '0 : 32'h8000_0000;
      else if (is_u) wres = is_r ? a[31:0] % b[31:0] : a[31:0] / b[31:0];
      else wres = is_r ? wa % wb : wa / wb;
      return {{32{wres[31]}}, wres};  // sign extend every word result
    end
    sa = a;
    sb = b;
    if (b == '0) return is_r ? a : '1;
    if (!is_u && a == {1'b1, 63'b0} && b == '1) return is_r ? '0 : {1'b1, 63'b0};
    if (is_u) return is_r ? a % b : a / b;
    return is_r ? sa % sb : sa / sb;
  endfunction

  task automatic check(string name, xlen_t expected, xlen_t actual);
    if (expected !== actual) begin
      $display("Fail time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic load_vectors();
    int          fd;
    string       line;
    logic [31:0] op;
    xlen_t       a;
    xlen_t       b;
    xlen_t       e;
    int          d;
    fd = $fopen("tests/div_tests.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open tests/div_tests.txt");
      errors++;
    end else begin
      while ($fgets(line, fd)) begin
        if ($sscanf(line, "%h %h %h %h %d", op, a, b, e, d) == 5) begin  // skips comments
          vec_op.push_back(op[2:0]);
          vec_a.push_back(a);
          vec_b.push_back(b);
          vec_exp.push_back(e);
          vec_delay.push_back(d);
        end
      end
      $fclose(fd);
    end
    loaded = 1'b1;
  endtask

  // ----------------------------------------
  // one operation with handshake checks
  // ----------------------------------------
  task automatic run_op(div_op_t op, xlen_t a, xlen_t b, xlen_t expected, int delay);
    int cycles;
    n_ops++;
    check("busy_o before start", 64'd0, busy_o);
    op_i       = op;
    dividend_i = a;
    divisor_i  = b;
    valid_i    = 1'b1;
    @(negedge clk);
    valid_i = 1'b0;
    cycles  = 1;
    check("busy_o after start", 64'd1, busy_o);
    while (done_o !== 1'b1 && cycles < 100) begin
      valid_i = (cycles == 2);  // second start while busy
      if (cycles == 2) begin
        op_i       = op ^ 3'b001;
        dividend_i = ~a;
        divisor_i  = 64'd3;
      end
      @(negedge clk);
      cycles++;
    end
    valid_i = 1'b0;
    if (done_o !== 1'b1) begin
      $display("error at %0t: done_o did not rise within 100 cycles of the start", $time);
      errors++;
      return;
    end
    check("done_o latency", expected_latency(op, a, b), cycles);
    check("result_o", expected, result_o);
    repeat (delay) begin
      @(negedge clk);
      check("done_o under back-pressure", 64'd1, done_o);
      check("result_o under back-pressure", expected, result_o);
    end
    ready_i = 1'b1;
    @(negedge clk);
    ready_i = 1'b0;
    check("busy_o after transfer", 64'd0, busy_o);
    check("done_o after transfer", 64'd0, done_o);
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin : main
    logic [31:0] r;
    div_op_t     op;
    xlen_t       a;
    xlen_t       b;
    rst_n      = 1'b1;
    valid_i    = 1'b0;
    op_i       = '0;
    dividend_i = '0;
    divisor_i  = '0;
    ready_i    = 1'b0;
    load_vectors();
    repeat (2) @(negedge clk);
    rst_n = 1'b0;
    check("busy_o after reset", 64'd0, busy_o);
    check("done_o after reset", 64'd0, done_o);
    check("result_o after reset", 64'd0, result_o);

    foreach (vec_op[i]) begin
      check("reference model", vec_exp[i], ref_div(vec_op[i], vec_a[i], vec_b[i]));
      run_op(vec_op[i], vec_a[i], vec_b[i], vec_exp[i], vec_delay[i]);
    end

    for (int i = 0; i < N_RANDOM; i++) begin
      r  = next_random();
      op = r[2:0];
      a  = {next_random(), next_random()};
      b  = {next_random(), next_random()} >> r[8:3];  // spread divisor sizes
      if (r[11:9] == 3'd0) begin
        if (r[12]) begin
          if (op[OP_BIT_WORD]) b[31:0] = '0;
          else b = '0;
        end else if (op[OP_BIT_WORD]) begin
          a[31:0] = 32'h8000_0000;
          b[31:0] = 32'hffff_ffff;
        end else begin
          a = {1'b1, 63'b0};
          b = '1;
        end
      end
      run_op(op, a, b, ref_div(op, a, b), int'(r[14:13]));
    end

    $display("%0d operations, %0d errors", n_ops, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // worst case about 70 cycles per operation
  initial begin : watchdog
    wait (loaded);
    #((vec_op.size() + N_RANDOM) * 70 * CLK_PERIOD + 100 * CLK_PERIOD);
    $display("timeout: the operations did not finish in the expected time");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule
